//--- project.f
+incdir+design
design/roadf_mem_pkg.sv
design/roadf_dwnld_pkg.sv
design/roadf_rom_slot.sv
design/roadf_sdram_arb.sv
design/roadf_dwnld.sv
design/roadf_game.sv
bench/roadf_sdram_model.sv
bench/roadf_game_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f \
    --top-module roadf_game_tb -o roadf_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/roadf_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1

//--- bench/roadf_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "roadf_consts.svh"

module roadf_game_tb;
    import roadf_mem_pkg::*;
    import roadf_dwnld_pkg::*;

    localparam logic [21:0] SCR_START  = `ROADF_SCR_START;
    localparam logic [21:0] OBJ_START  = `ROADF_OBJ_START;
    localparam logic [21:0] PCM_START  = `ROADF_PCM_START;
    localparam logic [24:0] PROM_START = `ROADF_PROM_START;

    localparam int N_BYTES  = 8;
    localparam int N_FETCH  = 8;
    localparam int FETCH_WC = 20;                  // Ack, gaps and arbiter overhead
    localparam int WC_SUM   = 10 + 4 * N_BYTES * 2 + N_FETCH * (FETCH_WC + 2) +
                              N_FETCH * (2 * FETCH_WC + 2) + 4 * (FETCH_WC + 2) +
                              12 + 6 * 6;
    localparam int LIMIT    = 20 * WC_SUM;

    logic        clk;
    logic        rst_n;
    logic        downloading;
    ioctl_wr_t   ioctl;
    prog_wr_t    prog;
    slot_req_t   scr;
    slot_req_t   obj;
    scr_word_t   scr_data;
    obj_word_t   obj_data;
    logic        scr_ok;
    logic        obj_ok;
    logic        sdram_req;
    logic [21:0] sdram_addr;
    logic        sdram_ack;
    logic        data_dst;
    logic        data_rdy;
    logic [15:0] data_read;

    prog_wr_t    exp_prog;
    scr_word_t   exp_scr;
    obj_word_t   exp_obj;
    logic [21:0] exp_addr;
    logic        quiet_chk;
    logic        hit_chk;
    logic        holdoff_chk;
    logic        order_chk;
    string       test_name;
    int          errors;
    int          err_start;
    int          tests;
    int          failed;
    int          cycles;
    logic [15:0] last_scr;

    roadf_game dut (.*);

    roadf_sdram_model u_mem (.*);

    always #20 clk = ~clk;

    function automatic logic [15:0] expected_word(input logic [21:0] a);
        return a[15:0] ^ 16'h5A3C;
    endfunction

    // Programming write that a loader byte should produce
    function automatic prog_wr_t expected_prog(input ioctl_wr_t w);
        prog_wr_t    p;
        logic [23:0] wa;
        p  = '0;
        wa = w.addr[24:1];
        if (w.addr >= PROM_START) begin
            p.prom_we = w.wr;
            p.addr    = 22'(w.addr - PROM_START);
            p.data    = w.dout;
        end else begin
            p.we   = w.wr;
            p.addr = wa[21:0];
            p.mask = w.addr[0] ? 2'b01 : 2'b10;
            p.data = (wa >= 24'(SCR_START) && wa < 24'(PCM_START)) ?
                     {w.dout[3:0], w.dout[7:4]} : w.dout;
        end
        return p;
    endfunction

    function automatic bit prog_matches(input prog_wr_t e, input prog_wr_t a);
        if (e.we != a.we || e.prom_we != a.prom_we) return 1'b0;
        if (e.we) return e.addr == a.addr && e.data == a.data && e.mask == a.mask;
        if (e.prom_we) return e.addr == a.addr && e.data == a.data;
        return 1'b1;
    endfunction

    always @(posedge clk) exp_prog <= expected_prog(ioctl);   // One-cycle reference

    // SDRAM word address of the fetch that is still waiting
    assign exp_addr = (scr.cs && !scr_ok) ? SCR_START + 22'(scr.addr)
                                          : OBJ_START + 22'({obj.addr, 1'b0});

    assert property (@(posedge clk) quiet_chk |->
                     !(sdram_req || scr_ok || obj_ok || prog.we || prog.prom_we))
    else begin
        errors++;
        $display("%s: an output went high after reset before any stimulus", test_name);
    end

    assert property (@(posedge clk) disable iff (!rst_n) prog_matches(exp_prog, prog))
    else begin
        errors++;
        $display("ERR %s: prog expected %h actual %h", test_name,
                 $sampled(exp_prog), $sampled(prog));
    end

    assert property (@(posedge clk) disable iff (!rst_n) scr_ok |-> scr_data == exp_scr)
    else begin
        errors++;
        $display("ERR %s: scr_data expected %h actual %h", test_name,
                 $sampled(exp_scr), $sampled(scr_data));
    end

    assert property (@(posedge clk) disable iff (!rst_n) obj_ok |-> obj_data == exp_obj)
    else begin
        errors++;
        $display("ERR %s: obj_data expected %h actual %h", test_name,
                 $sampled(exp_obj), $sampled(obj_data));
    end

    assert property (@(posedge clk) disable iff (!rst_n) sdram_req |-> sdram_addr == exp_addr)
    else begin
        errors++;
        $display("ERR %s: sdram_addr expected %h actual %h", test_name,
                 $sampled(exp_addr), $sampled(sdram_addr));
    end

    assert property (@(posedge clk) disable iff (!rst_n)
                     order_chk && obj_ok |-> scr_ok && $past(scr_ok))
    else begin
        errors++;
        $display("%s: object ok rose without scroll ok ahead of it", test_name);
    end

    assert property (@(posedge clk) disable iff (!rst_n) hit_chk && $rose(scr.cs) |=> scr_ok)
    else begin
        errors++;
        $display("%s: cache hit gave no ok one cycle after cs", test_name);
    end

    assert property (@(posedge clk) disable iff (!rst_n) (hit_chk || holdoff_chk) |-> !sdram_req)
    else begin
        errors++;
        $display("%s: sdram_req went high when no request was allowed", test_name);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout after %0d cycles, a fetch never completed", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
        tests++;
    endtask

    task automatic end_test();
        repeat (3) @(posedge clk);                  // Let the prog pipeline drain
        if (errors == err_start) begin
            $display("Test %-12s passed", test_name);
        end else begin
            failed++;
            $display("Test %-12s failed with %0d errors", test_name, errors - err_start);
        end
    endtask

    task automatic load_byte(input logic [24:0] a, input logic [7:0] d);
        @(posedge clk);
        ioctl.wr   <= 1'b1;
        ioctl.addr <= a;
        ioctl.dout <= d;
        @(posedge clk);
        ioctl.wr   <= 1'b0;
    endtask

    // Holds cs until ok, then releases and idles one cycle
    task automatic fetch(input bit is_obj, input logic [15:0] a);
        @(posedge clk);
        if (is_obj) begin
            obj.cs  <= 1'b1;
            obj.addr <= a;
            exp_obj <= {expected_word(OBJ_START + 22'({a, 1'b1})),
                        expected_word(OBJ_START + 22'({a, 1'b0}))};
        end else begin
            scr.cs  <= 1'b1;
            scr.addr <= a;
            exp_scr <= expected_word(SCR_START + 22'(a));
            last_scr = a;
        end
        do @(negedge clk); while (!(is_obj ? obj_ok : scr_ok));
        @(posedge clk);
        scr.cs <= 1'b0;
        obj.cs <= 1'b0;
        @(posedge clk);
    endtask

    task automatic fetch_pair(input logic [15:0] sa, input logic [15:0] oa);
        @(posedge clk);
        scr.cs   <= 1'b1;
        scr.addr <= sa;
        obj.cs   <= 1'b1;
        obj.addr <= oa;
        exp_scr  <= expected_word(SCR_START + 22'(sa));
        exp_obj  <= {expected_word(OBJ_START + 22'({oa, 1'b1})),
                     expected_word(OBJ_START + 22'({oa, 1'b0}))};
        order_chk <= 1'b1;
        last_scr = sa;
        do @(negedge clk); while (!(scr_ok && obj_ok));
        @(posedge clk);
        scr.cs    <= 1'b0;
        obj.cs    <= 1'b0;
        order_chk <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(15206));
        clk = 1'b0;
        rst_n = 1'b0;
        downloading = 1'b0;
        ioctl = '0;
        scr = '0;
        obj = '0;
        exp_scr = '0;
        exp_obj = '0;
        quiet_chk = 1'b0;
        hit_chk = 1'b0;
        holdoff_chk = 1'b0;
        order_chk = 1'b0;
        errors = 0;
        tests = 0;
        failed = 0;
        cycles = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset");
        quiet_chk <= 1'b1;
        repeat (6) @(posedge clk);
        quiet_chk <= 1'b0;
        end_test();

        start_test("download");
        for (int i = 0; i < N_BYTES; i++) begin
            load_byte(25'($urandom_range(0, 'h0FFFF)), 8'($urandom));        // Below
            load_byte(25'($urandom_range('h10000, 'h27FFF)), 8'($urandom));  // Graphics
            load_byte(25'($urandom_range('h28000, 'h3FFFF)), 8'($urandom));  // Above
        end
        end_test();

        start_test("prom");
        for (int i = 0; i < N_BYTES; i++) begin
            load_byte(PROM_START + 25'($urandom_range(0, 'hFFF)), 8'($urandom));
        end
        end_test();

        start_test("scroll");
        for (int i = 0; i < N_FETCH; i++) fetch(1'b0, 16'($urandom));
        end_test();

        start_test("object");
        for (int i = 0; i < N_FETCH / 2; i++) fetch(1'b1, 16'($urandom));
        for (int i = 0; i < N_FETCH / 2; i++) fetch_pair(16'($urandom), 16'($urandom));
        end_test();

        start_test("cache");
        fetch(1'b0, last_scr ^ 16'h0001);
        hit_chk <= 1'b1;
        fetch(1'b0, last_scr);
        hit_chk <= 1'b0;
        @(posedge clk);
        downloading <= 1'b1;
        holdoff_chk <= 1'b1;
        fork
            fetch(1'b0, last_scr ^ 16'h0010);
            begin
                repeat (12) @(posedge clk);
                downloading <= 1'b0;
                holdoff_chk <= 1'b0;
            end
        join
        end_test();

        $display("Tests: %0d run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/roadf_sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "roadf_consts.svh"

module roadf_sdram_model (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       sdram_req,
    input  wire logic [`ROADF_SDRAM_AW-1:0] sdram_addr,
    output logic                            sdram_ack,
    output logic                            data_dst,
    output logic                            data_rdy,
    output logic [15:0]                     data_read
);

    // Every word holds its own address scrambled with a constant
    function automatic logic [15:0] word_at(input logic [`ROADF_SDRAM_AW-1:0] a);
        return a[15:0] ^ 16'h5A3C;
    endfunction

    logic [`ROADF_SDRAM_AW-1:0] addr;

    initial begin
        sdram_ack = 1'b0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            // Requests are sampled away from the active edge
            do @(negedge clk); while (!(rst_n && sdram_req));
            addr = sdram_addr;

            repeat ($urandom_range(1, 4)) @(posedge clk);
            sdram_ack <= 1'b1;
            @(posedge clk);
            sdram_ack <= 1'b0;

            repeat ($urandom_range(0, 2)) @(posedge clk);
            data_read <= word_at(addr);
            data_dst  <= 1'b1;                  // First word
            @(posedge clk);
            data_dst  <= 1'b0;

            repeat ($urandom_range(0, 2)) @(posedge clk);
            data_read <= word_at(addr + 22'd1);
            data_rdy  <= 1'b1;                  // Second word
            @(posedge clk);
            data_rdy  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/roadf_game.sv
`timescale 1ns/1ps
`default_nettype none

`include "roadf_consts.svh"

module roadf_game (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       downloading,
    // ROM loader
    input  wire roadf_dwnld_pkg::ioctl_wr_t ioctl,
    output wire roadf_dwnld_pkg::prog_wr_t  prog,
    // Scroll fetcher
    input  wire roadf_mem_pkg::slot_req_t   scr,
    output wire roadf_mem_pkg::scr_word_t   scr_data,
    output wire logic                       scr_ok,
    // Object fetcher
    input  wire roadf_mem_pkg::slot_req_t   obj,
    output wire roadf_mem_pkg::obj_word_t   obj_data,
    output wire logic                       obj_ok,
    // SDRAM
    output wire logic                       sdram_req,
    output wire logic [`ROADF_SDRAM_AW-1:0] sdram_addr,
    input  wire logic                       sdram_ack,
    input  wire logic                       data_dst,
    input  wire logic                       data_rdy,
    input  wire logic [15:0]                data_read
);
    import roadf_mem_pkg::*;

    localparam logic [`ROADF_SDRAM_AW-1:0] SCR_START = `ROADF_SCR_START;
    localparam logic [`ROADF_SDRAM_AW-1:0] OBJ_START = `ROADF_OBJ_START;

    sdram_req_t scr_sdram;
    sdram_req_t obj_sdram;
    sdram_rsp_t scr_rsp;
    sdram_rsp_t obj_rsp;

    roadf_rom_slot #(.data_t(scr_word_t), .OFFSET(SCR_START)) u_scr (
        .clk    ( clk       ),
        .rst_n  ( rst_n     ),
        .slot   ( scr       ),
        .data   ( scr_data  ),
        .ok     ( scr_ok    ),
        .sdram  ( scr_sdram ),
        .rsp    ( scr_rsp   )
    );

    roadf_rom_slot #(.data_t(obj_word_t), .OFFSET(OBJ_START)) u_obj (
        .clk    ( clk       ),
        .rst_n  ( rst_n     ),
        .slot   ( obj       ),
        .data   ( obj_data  ),
        .ok     ( obj_ok    ),
        .sdram  ( obj_sdram ),
        .rsp    ( obj_rsp   )
    );

    roadf_sdram_arb u_arb (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .scr_req     ( scr_sdram   ),   // Higher priority
        .obj_req     ( obj_sdram   ),
        .scr_rsp     ( scr_rsp     ),
        .obj_rsp     ( obj_rsp     ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_dst    ( data_dst    ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

    roadf_dwnld u_dwnld (
        .clk    ( clk   ),
        .rst_n  ( rst_n ),
        .ioctl  ( ioctl ),
        .prog   ( prog  )
    );

endmodule

`default_nettype wire

//--- design/roadf_dwnld.sv
`timescale 1ns/1ps
`default_nettype none

`include "roadf_consts.svh"

module roadf_dwnld (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire roadf_dwnld_pkg::ioctl_wr_t ioctl,
    output roadf_dwnld_pkg::prog_wr_t       prog
);
    import roadf_dwnld_pkg::*;

    localparam int WAW = `ROADF_IOCTL_AW - 1;   // Loader word address width

    localparam logic [`ROADF_SDRAM_AW-1:0] SCR_START  = `ROADF_SCR_START;
    localparam logic [`ROADF_SDRAM_AW-1:0] PCM_START  = `ROADF_PCM_START;
    localparam logic [`ROADF_IOCTL_AW-1:0] PROM_START = `ROADF_PROM_START;

    logic                       is_prom;
    logic                       is_gfx;
    logic [WAW-1:0]             word_addr;
    logic [`ROADF_IOCTL_AW-1:0] prom_addr;
    logic [7:0]                 byte_out;
    logic [1:0]                 lane_mask;
    logic                       we_q;
    logic                       prom_we_q;
    logic [`ROADF_SDRAM_AW-1:0] addr_q;
    logic [7:0]                 data_q;
    logic [1:0]                 mask_q;

    assign is_prom   = ioctl.addr >= PROM_START;
    assign word_addr = ioctl.addr[`ROADF_IOCTL_AW-1:1];
    assign prom_addr = ioctl.addr - PROM_START;

    // Graphics ROMs are stored with swapped nibbles
    assign is_gfx = !is_prom && (word_addr >= WAW'(SCR_START)) &&
                    (word_addr < WAW'(PCM_START));

    assign byte_out  = is_gfx ? {ioctl.dout[3:0], ioctl.dout[7:4]} : ioctl.dout;
    assign lane_mask = ioctl.addr[0] ? 2'b01 : 2'b10;  // Odd bytes go high

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q      <= 1'b0;
            prom_we_q <= 1'b0;
        end else begin
            we_q      <= ioctl.wr && !is_prom;
            prom_we_q <= ioctl.wr &&  is_prom;
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl.wr) begin
            addr_q <= is_prom ? prom_addr[`ROADF_SDRAM_AW-1:0]
                              : word_addr[`ROADF_SDRAM_AW-1:0];
            data_q <= byte_out;
            mask_q <= lane_mask;
        end
    end

    assign prog = prog_wr_t'{
        we:      we_q,
        prom_we: prom_we_q,
        addr:    addr_q,
        data:    data_q,
        mask:    mask_q
    };

endmodule

`default_nettype wire

//--- design/roadf_sdram_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "roadf_consts.svh"

module roadf_sdram_arb (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       downloading,
    input  wire roadf_mem_pkg::sdram_req_t  scr_req,
    input  wire roadf_mem_pkg::sdram_req_t  obj_req,
    output roadf_mem_pkg::sdram_rsp_t       scr_rsp,
    output roadf_mem_pkg::sdram_rsp_t       obj_rsp,
    output logic                            sdram_req,
    output logic [`ROADF_SDRAM_AW-1:0]      sdram_addr,
    input  wire logic                       sdram_ack,
    input  wire logic                       data_dst,
    input  wire logic                       data_rdy,
    input  wire logic [15:0]                data_read
);
    import roadf_mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,     // Waiting for ack
        ST_FIRST,   // Waiting for data_dst
        ST_SECOND   // Waiting for data_rdy
    } state_t;

    state_t      state;
    logic        sel_obj;     // Granted slot
    logic        done_q;
    logic        start;
    logic [15:0] first_word;
    logic [31:0] burst;

    // The slot still shows its old request in the done cycle
    assign start = (state == ST_IDLE) && !downloading && !done_q &&
                   (scr_req.req || obj_req.req);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            sel_obj   <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        sel_obj   <= !scr_req.req;  // Scroll wins ties
                        sdram_req <= 1'b1;
                        state     <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ST_FIRST;
                    end
                end
                ST_FIRST: begin
                    if (data_dst) state <= ST_SECOND;
                end
                ST_SECOND: begin
                    if (data_rdy) begin
                        done_q <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= scr_req.req ? scr_req.addr : obj_req.addr;
        end
        if (state == ST_FIRST && data_dst) begin
            first_word <= data_read;
        end
        if (state == ST_SECOND && data_rdy) begin
            burst <= {data_read, first_word};
        end
    end

    assign scr_rsp = sdram_rsp_t'{done: done_q && !sel_obj, data: burst};
    assign obj_rsp = sdram_rsp_t'{done: done_q &&  sel_obj, data: burst};

endmodule

`default_nettype wire

//--- design/roadf_rom_slot.sv
`timescale 1ns/1ps
`default_nettype none

`include "roadf_consts.svh"

module roadf_rom_slot #(
    parameter type                        data_t = logic [15:0],
    parameter logic [`ROADF_SDRAM_AW-1:0] OFFSET = '0
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire roadf_mem_pkg::slot_req_t  slot,
    output data_t                          data,
    output logic                           ok,
    output roadf_mem_pkg::sdram_req_t      sdram,
    input  wire roadf_mem_pkg::sdram_rsp_t rsp
);
    import roadf_mem_pkg::*;

    localparam int DW    = $bits(data_t);
    localparam int SHIFT = (DW > 16) ? 1 : 0;  // 32-bit payloads take two words

    logic [`ROADF_SLOT_AW-1:0]  cache_addr;
    logic                       cache_valid;
    data_t                      cache_data;
    logic                       ok_q;
    logic                       hit;
    logic                       miss;
    logic                       fill;
    logic                       req_on;
    logic [`ROADF_SDRAM_AW-1:0] req_addr;
    logic [`ROADF_SDRAM_AW-1:0] word_addr;

    assign hit  = cache_valid && (cache_addr == slot.addr);
    assign miss = slot.cs && !hit && !req_on;   // Start a new request
    assign fill = req_on && rsp.done;

    // Scale payload address to SDRAM words
    assign word_addr = OFFSET + (`ROADF_SDRAM_AW'(slot.addr) << SHIFT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cache_valid <= 1'b0;
            ok_q        <= 1'b0;
            req_on      <= 1'b0;
        end else begin
            // Fill counts as a hit so ok follows done by one cycle
            ok_q <= slot.cs && (hit || fill);
            if (miss) begin
                req_on <= 1'b1;
            end else if (fill) begin
                req_on      <= 1'b0;
                cache_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            req_addr <= word_addr;
        end
        if (fill) begin
            cache_addr <= slot.addr;                  // Fetcher holds addr until ok
            cache_data <= data_t'(rsp.data[DW-1:0]);  // Low word only for 16 bits
        end
    end

    assign sdram = sdram_req_t'{req: req_on, addr: req_addr};
    assign data  = cache_data;
    assign ok    = ok_q && slot.cs && hit;

endmodule

`default_nettype wire

//--- design/roadf_dwnld_pkg.sv
`default_nettype none

`include "roadf_consts.svh"

package roadf_dwnld_pkg;

    // One byte from the ROM loader
    typedef struct packed {
        logic                       wr;
        logic [`ROADF_IOCTL_AW-1:0] addr;
        logic [7:0]                 dout;
    } ioctl_wr_t;

    // One programming write to SDRAM or PROM
    typedef struct packed {
        logic                       we;
        logic                       prom_we;
        logic [`ROADF_SDRAM_AW-1:0] addr;
        logic [7:0]                 data;
        logic [1:0]                 mask;   // Active low byte lanes
    } prog_wr_t;

endpackage

`default_nettype wire

//--- design/roadf_mem_pkg.sv
`default_nettype none

`include "roadf_consts.svh"

package roadf_mem_pkg;

    // Payload words seen by the fetchers
    typedef logic [15:0] scr_word_t;
    typedef logic [31:0] obj_word_t;

    // Fetcher to slot
    typedef struct packed {
        logic                       cs;
        logic [`ROADF_SLOT_AW-1:0]  addr;   // In payload units
    } slot_req_t;

    // Slot to arbiter and held until done
    typedef struct packed {
        logic                       req;
        logic [`ROADF_SDRAM_AW-1:0] addr;   // SDRAM word address
    } sdram_req_t;

    // Arbiter to slot
    typedef struct packed {
        logic                       done;   // One-cycle pulse
        logic [31:0]                data;   // Second word high, first word low
    } sdram_rsp_t;

endpackage

`default_nettype wire

//--- design/roadf_consts.svh
`ifndef ROADF_CONSTS_SVH
`define ROADF_CONSTS_SVH

// SDRAM word offsets of the ROM regions
`define ROADF_SCR_START  22'h00_8000
`define ROADF_OBJ_START  22'h00_C000
`define ROADF_PCM_START  22'h01_4000    // Graphics region ends here

// Loader byte address of the first PROM
`define ROADF_PROM_START 25'h004_0000

// Address widths
`define ROADF_SDRAM_AW   22             // SDRAM word address
`define ROADF_IOCTL_AW   25             // Loader byte address
`define ROADF_SLOT_AW    16             // Fetcher address, payload units

`endif
